// File: eth_fcs.f
rtl/eth_fcs_pkg.sv
rtl/crc32_word_engine.sv
rtl/frame_sequencer.sv
rtl/fcs_result.sv
rtl/eth_fcs_top.sv
sim/tb_eth_fcs.sv

// File: rtl/crc32_word_engine.sv
// crc32 word engine: one 32-bit word per req/ack, three-stage CRC-32 update
`timescale 1ns/1ps

module crc32_word_engine #(
    parameter logic [31:0] POLY = 32'h04C11DB7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  eth_fcs_pkg::word_t data,
    input  logic               first,
    output logic               ack,
    output logic               done,
    output eth_fcs_pkg::crc_t  crc
);

    eth_fcs_pkg::eng_state_t state;

    // stage 1: reversed word and seed select
    eth_fcs_pkg::word_t rev_d;
    eth_fcs_pkg::word_t rev_q;
    logic               first_q;

    // stage 2: register after the first 16 shift steps
    eth_fcs_pkg::crc_t  seed;
    eth_fcs_pkg::crc_t  xord;
    eth_fcs_pkg::crc_t  half_d;
    eth_fcs_pkg::crc_t  half_q;
    logic               half_v;

    // stage 3: remaining 16 steps, straight into crc
    eth_fcs_pkg::crc_t  full_d;

    // 16 steps of msb-first polynomial division
    function automatic eth_fcs_pkg::crc_t shift16(input eth_fcs_pkg::crc_t val);
        eth_fcs_pkg::crc_t r;
        r = val;
        for (int i = 0; i < 16; i++) begin
            r = {r[30:0], 1'b0} ^ (POLY & {32{r[31]}});
        end
        return r;
    endfunction

    // reflected ethernet order: byte lsb first becomes word msb first
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            rev_d[i] = data[31-i];
        end
    end

    // running register unless this word opens a frame
    assign seed   = first_q ? eth_fcs_pkg::CRC_INIT : crc;
    assign xord   = seed ^ rev_q;
    assign half_d = shift16(xord);
    assign full_d = shift16(half_q);

    // control: state, ack pulse and stage valids
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= eth_fcs_pkg::ENG_IDLE;
            ack    <= 1'b0;
            half_v <= 1'b0;
            done   <= 1'b0;
        end else begin
            // ack doubles as the stage 1 valid
            ack    <= 1'b0;
            half_v <= ack;
            done   <= half_v;
            case (state)
                eth_fcs_pkg::ENG_IDLE: begin
                    if (req) begin
                        ack   <= 1'b1;
                        state <= eth_fcs_pkg::ENG_BUSY;
                    end
                end
                eth_fcs_pkg::ENG_BUSY: begin
                    // back to idle one cycle after done
                    if (done) begin
                        state <= eth_fcs_pkg::ENG_IDLE;
                    end
                end
                default: state <= eth_fcs_pkg::ENG_IDLE;
            endcase
        end
    end

    // stage registers carry payload only
    always_ff @(posedge clk) begin
        if (state == eth_fcs_pkg::ENG_IDLE && req) begin
            rev_q   <= rev_d;
            first_q <= first;
        end
        if (ack) begin
            half_q <= half_d;
        end
    end

    // crc itself restarts at the seed
    always_ff @(posedge clk) begin
        if (rst) begin
            crc <= eth_fcs_pkg::CRC_INIT;
        end else if (half_v) begin
            crc <= full_d;
        end
    end

    // one ack per accepted request
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        ack |=> !ack
    ) else $error("crc32_word_engine: ack high two cycles in a row");

    // the requester must hold req until the engine answers
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (rst)
        req && !ack |=> req
    ) else $error("crc32_word_engine: req dropped before ack");

endmodule

// File: rtl/eth_fcs_pkg.sv
// eth fcs package: shared word and crc types, CRC-32 constants, FSM encodings
package eth_fcs_pkg;

    // one frame word, byte 0 in bits 7:0
    typedef logic [31:0] word_t;

    // crc register value, msb-first (non-reflected) form
    typedef logic [31:0] crc_t;

    // seed at every frame start
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

    // raw register left over after a good frame that carries its own fcs
    localparam crc_t CRC_RESIDUE = 32'hC704_DD7B;

    // word engine states
    typedef enum logic {
        ENG_IDLE,
        ENG_BUSY
    } eng_state_t;

    // frame sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT,
        SEQ_FINISH
    } seq_state_t;

endpackage

// File: rtl/eth_fcs_top.sv
// eth fcs top: sequencer, crc32 word engine and result stage
`timescale 1ns/1ps

module eth_fcs_top #(
    parameter logic [31:0] POLY = 32'h04C11DB7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               word_strobe,
    input  eth_fcs_pkg::word_t word,
    input  logic               last,
    output logic               busy,
    output eth_fcs_pkg::crc_t  fcs,
    output logic               fcs_valid,
    output logic               fcs_ok
);

    // sequencer to engine
    logic               req;
    logic               ack;
    logic               done;
    logic               first;
    eth_fcs_pkg::word_t data;

    // engine and sequencer to result stage
    eth_fcs_pkg::crc_t  crc;
    logic               frame_end;

    frame_sequencer seq0 (
        .clk         (clk),
        .rst         (rst),
        .word_strobe (word_strobe),
        .word        (word),
        .last        (last),
        .busy        (busy),
        .req         (req),
        .data        (data),
        .first       (first),
        .ack         (ack),
        .done        (done),
        .frame_end   (frame_end)
    );

    crc32_word_engine #(
        .POLY (POLY)
    ) eng0 (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .data  (data),
        .first (first),
        .ack   (ack),
        .done  (done),
        .crc   (crc)
    );

    fcs_result res0 (
        .clk       (clk),
        .rst       (rst),
        .frame_end (frame_end),
        .crc       (crc),
        .fcs       (fcs),
        .fcs_ok    (fcs_ok),
        .fcs_valid (fcs_valid)
    );

endmodule

// File: rtl/fcs_result.sv
// fcs result stage: registers the frame fcs and the residue verdict at frame end
`timescale 1ns/1ps

module fcs_result (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_end,
    input  eth_fcs_pkg::crc_t crc,
    output eth_fcs_pkg::crc_t fcs,
    output logic              fcs_ok,
    output logic              fcs_valid
);

    // fcs and verdict as seen at the frame end
    eth_fcs_pkg::crc_t fcs_d;
    logic              ok_d;

    // transmit side sends the complemented register
    assign fcs_d = ~crc;

    // receive side, frame already holds its fcs word
    assign ok_d = (crc == eth_fcs_pkg::CRC_RESIDUE);

    always_ff @(posedge clk) begin
        if (rst) begin
            fcs       <= '0;
            fcs_ok    <= 1'b0;
            fcs_valid <= 1'b0;
        end else begin
            fcs_valid <= frame_end;
            // both results hold until the next frame closes
            if (frame_end) begin
                fcs    <= fcs_d;
                fcs_ok <= ok_d;
            end
        end
    end

    // single pulse per frame
    valid_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        fcs_valid |=> !fcs_valid
    ) else $error("fcs_result: fcs_valid longer than one cycle");

endmodule

// File: rtl/frame_sequencer.sv
// frame sequencer: takes strobed frame words and feeds them to the crc engine
`timescale 1ns/1ps

module frame_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               word_strobe,
    input  eth_fcs_pkg::word_t word,
    input  logic               last,
    output logic               busy,
    output logic               req,
    output eth_fcs_pkg::word_t data,
    output logic               first,
    input  logic               ack,
    input  logic               done,
    output logic               frame_end
);

    eth_fcs_pkg::seq_state_t state;

    // last flag of the word in flight
    logic last_q;

    // high between the first and the last word of a frame
    logic in_frame;

    // word accepted from the source
    logic take;

    // outputs decode straight from the state
    assign req       = (state == eth_fcs_pkg::SEQ_ISSUE);
    assign busy      = (state == eth_fcs_pkg::SEQ_ISSUE) ||
                       (state == eth_fcs_pkg::SEQ_WAIT);
    assign frame_end = (state == eth_fcs_pkg::SEQ_FINISH);

    // strobes while busy are dropped
    assign take = word_strobe && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= eth_fcs_pkg::SEQ_IDLE;
            in_frame <= 1'b0;
            first    <= 1'b0;
        end else begin
            case (state)
                // the frame_end cycle also takes a new word
                eth_fcs_pkg::SEQ_IDLE,
                eth_fcs_pkg::SEQ_FINISH: begin
                    if (take) begin
                        first <= !in_frame;
                        state <= eth_fcs_pkg::SEQ_ISSUE;
                    end else begin
                        state <= eth_fcs_pkg::SEQ_IDLE;
                    end
                end
                eth_fcs_pkg::SEQ_ISSUE: begin
                    // req falls the cycle after ack
                    if (ack) begin
                        state <= eth_fcs_pkg::SEQ_WAIT;
                    end
                end
                eth_fcs_pkg::SEQ_WAIT: begin
                    if (done) begin
                        if (last_q) begin
                            // close the frame, next word reseeds
                            in_frame <= 1'b0;
                            state    <= eth_fcs_pkg::SEQ_FINISH;
                        end else begin
                            in_frame <= 1'b1;
                            state    <= eth_fcs_pkg::SEQ_IDLE;
                        end
                    end
                end
                default: state <= eth_fcs_pkg::SEQ_IDLE;
            endcase
        end
    end

    // word and last flag held until the next accepted strobe
    always_ff @(posedge clk) begin
        if (take) begin
            data   <= word;
            last_q <= last;
        end
    end

    // source must respect busy
    no_strobe_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        word_strobe |-> !busy
    ) else $error("frame_sequencer: word_strobe while busy, word ignored");

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the eth fcs testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_eth_fcs \
    -f eth_fcs.f -o tb_eth_fcs > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_eth_fcs > sim.log 2>&1
grep -qx "Done: no errors" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sim/eth_fcs_vectors.txt
# w lines give one frame word in hex and its last flag
# e lines close a frame with the expected fcs and fcs_ok
# single words, the all-ones word leaves a zero register behind
w ffffffff 1
e ffffffff 0
w 00000000 1
e 38fb2284 1
w 7fffffff 1
e fb3ee248 0
w 80000000 1
e 3c3a3f33 0
# check string 123456789 padded with bytes d9 c6 0b
w 34333231 0
w 38373635 0
w 0bc6d939 1
e d3ffffff 0
# same frame followed by its own fcs
w 34333231 0
w 38373635 0
w 0bc6d939 0
w ffffffcb 1
e 38fb2284 1
# fcs word with bit 31 flipped
w 34333231 0
w 38373635 0
w 0bc6d939 0
w 7fffffcb 1
e 3c3a3f33 0
# two and four word frames
w ffffffff 0
w 80000000 1
e fb3ee248 0
w 00000000 0
w a144df1c 1
e 3c3a3f33 0
w 00000000 0
w debb20e3 1
e ffffffff 0
w ffffffff 0
w 00000000 0
w 00000000 0
w ffffffff 1
e 38fb2284 1

// File: sim/tb_eth_fcs.sv
// testbench for eth_fcs_top: vector-driven frames with fcs and residue checks
`timescale 1ns/1ps

module tb_eth_fcs;

    localparam int WAIT_LIMIT  = 50;
    localparam int FCS_LATENCY = 6;

    // characters the vector reader reacts to
    localparam int CHAR_HASH = 35;
    localparam int CHAR_W    = 119;
    localparam int CHAR_E    = 101;

    logic        clk;
    logic        rst;
    logic        word_strobe;
    logic [31:0] word;
    logic        last;
    logic        busy;
    logic [31:0] fcs;
    logic        fcs_valid;
    logic        fcs_ok;

    int     errors;
    int     tests_run;
    int     tests_failed;
    integer seed;
    logic   stalled;

    // words of the frame being read from the vector file
    logic [31:0] frame_words[$];
    logic        frame_lasts[$];

    eth_fcs_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .word_strobe (word_strobe),
        .word        (word),
        .last        (last),
        .busy        (busy),
        .fcs         (fcs),
        .fcs_valid   (fcs_valid),
        .fcs_ok      (fcs_ok)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    // random number of idle cycles below span
    task automatic idle_cycles(input int span);
        int gap;
        gap = $unsigned($random(seed)) % span;
        repeat (gap) @(negedge clk);
    endtask

    task automatic wait_busy_low(output logic ready);
        int count;
        count = 0;
        while (busy && count < WAIT_LIMIT) begin
            @(negedge clk);
            count++;
        end
        ready = !busy;
        if (!ready) begin
            $display("timeout: busy stayed high for %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic run_frame(input int idx, input logic [31:0] exp_fcs, input logic exp_ok);
        int   errors_before;
        int   cycles;
        logic ready;
        errors_before = errors;
        idle_cycles(6);
        foreach (frame_words[i]) begin
            if (!stalled) begin
                wait_busy_low(ready);
                if (!ready) begin
                    stalled = 1'b1;
                end else begin
                    // extra gap once the sequencer is free again
                    idle_cycles(4);
                    word_strobe = 1'b1;
                    word        = frame_words[i];
                    last        = frame_lasts[i];
                    @(negedge clk);
                    word_strobe = 1'b0;
                    // busy rises the cycle after the strobe
                    if (busy !== 1'b1) begin
                        report_mismatch("busy", 32'd1, 32'(busy));
                    end
                end
            end
        end
        if (!stalled) begin
            // counts cycles since the last strobe
            cycles = 1;
            while (!fcs_valid && cycles < WAIT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (!fcs_valid) begin
                $display("timeout: fcs_valid never came after the last word of frame %0d", idx);
                errors++;
                stalled = 1'b1;
            end else begin
                if (cycles != FCS_LATENCY) begin
                    report_mismatch("fcs_valid latency", 32'(FCS_LATENCY), 32'(cycles));
                end
                if (fcs !== exp_fcs) begin
                    report_mismatch("fcs", exp_fcs, fcs);
                end
                if (fcs_ok !== exp_ok) begin
                    report_mismatch("fcs_ok", 32'(exp_ok), 32'(fcs_ok));
                end
                @(negedge clk);
                if (fcs_valid !== 1'b0) begin
                    report_mismatch("fcs_valid", 32'd0, 32'(fcs_valid));
                end
                if (fcs !== exp_fcs) begin
                    report_mismatch("fcs held", exp_fcs, fcs);
                end
            end
        end
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d: %0d word frame ok", idx, frame_words.size());
        end else begin
            tests_failed++;
            $display("test %0d: %0d word frame failed", idx, frame_words.size());
        end
    endtask

    initial begin
        int               fd;
        int               c;
        int               n;
        int               frame_idx;
        int               errors_before;
        logic [31:0]      val_a;
        logic [31:0]      val_b;
        logic [8*256-1:0] line;
        rst          = 1'b1;
        word_strobe  = 1'b0;
        word         = '0;
        last         = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'hf31e;
        stalled      = 1'b0;
        frame_idx    = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // outputs straight after reset
        errors_before = errors;
        if (busy !== 1'b0) begin
            report_mismatch("busy", 32'd0, 32'(busy));
        end
        if (fcs_valid !== 1'b0) begin
            report_mismatch("fcs_valid", 32'd0, 32'(fcs_valid));
        end
        if (fcs !== 32'h0) begin
            report_mismatch("fcs", 32'h0, fcs);
        end
        tests_run++;
        if (errors == errors_before) begin
            $display("test reset: ok");
        end else begin
            tests_failed++;
            $display("test reset: failed");
        end

        fd = $fopen("sim/eth_fcs_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/eth_fcs_vectors.txt");
            errors++;
        end else begin
            c = $fgetc(fd);
            while (c != -1 && !stalled) begin
                if (c == CHAR_HASH) begin
                    n = $fgets(line, fd);
                end else if (c == CHAR_W) begin
                    n = $fscanf(fd, "%h %h", val_a, val_b);
                    if (n != 2) begin
                        $display("malformed word line in the vector file");
                        errors++;
                    end else begin
                        frame_words.push_back(val_a);
                        frame_lasts.push_back(val_b[0]);
                    end
                end else if (c == CHAR_E) begin
                    n = $fscanf(fd, "%h %h", val_a, val_b);
                    if (n != 2 || frame_words.size() == 0) begin
                        $display("expected values without a complete frame in the vector file");
                        errors++;
                    end else begin
                        frame_idx++;
                        run_frame(frame_idx, val_a, val_b[0]);
                    end
                    frame_words.delete();
                    frame_lasts.delete();
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            if (frame_idx == 0) begin
                $display("the vector file held no frames");
                errors++;
            end
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
